/* src/flashSpi_consts.svh */
`ifndef FLASH_SPI_CONSTS_SVH
`define FLASH_SPI_CONSTS_SVH

// system clocks per sck half period
`define FLASH_CLK_DIV   4
// clocks from sck fall to mosi update, keep below the divider
`define FLASH_HOLD_CYC  2
// cs setup and hold around a frame
`define CS_GAP_CYC      4

// apb byte offsets
`define REG_CTRL        8'h00
`define REG_ADDR        8'h04
`define REG_WDATA       8'h08
`define REG_RDATA       8'h0C
`define REG_STATUS      8'h10

`define CTRL_START_BIT  8       // self clearing
`define STAT_BUSY_BIT   0
`define STAT_DONE_BIT   1       // sticky, cleared by status read

`endif

/* src/flashSpiPkg.sv */
package flashSpiPkg;

    // ----------------------------------------------------------
    // command sequencer states
    // ----------------------------------------------------------
    typedef enum logic [2:0]
    {
        IDLE,           // cs high, waiting for start
        CS_SETUP,       // cs low before first sck
        SEND_OP,        // opcode byte
        SEND_ADDR,      // three address bytes, msb first
        XFER_DATA,      // write byte or dummy 0xff on reads
        CS_HOLD         // cs low after last sck
    } cmdState;

    // ----------------------------------------------------------
    // nor flash opcodes handled here
    // ----------------------------------------------------------
    typedef enum logic [7:0]
    {
        OP_WREN = 8'h06,    // write enable, opcode only
        OP_RDSR = 8'h05,    // read status register
        OP_READ = 8'h03,    // read data, 24 bit address
        OP_PP   = 8'h02     // page program, one byte
    } flashOp;

endpackage

/* src/apbFlashRegs.sv */
`timescale 1ns/10ps
`include "flashSpi_consts.svh"

module apbFlashRegs
(
    input  logic                 iSysClk,
    input  logic                 rstN,
    input  logic                 pSel,
    input  logic                 pEnable,
    input  logic                 pWrite,
    input  logic [7:0]           pAddr,
    input  logic [31:0]          pWdata,
    output logic [31:0]          pRdata,
    output logic                 pSlvErr,
    input  logic                 busy,
    input  logic [7:0]           rdByte,
    input  logic                 rdByteVld,
    output logic                 cmdStart,
    output flashSpiPkg::flashOp  cmdOp,
    output logic [23:0]          cmdAddr,
    output logic [7:0]           cmdWrByte
);

    import flashSpiPkg::*;

    logic        accessCyc, wrAcc, rdAcc;
    logic        knownOff, opLegal, startReq;
    logic        ctrlWr, ctrlErr, ctrlAccept;
    logic        busyInt, busyQ, busyFell;
    logic        statusRd, doneFlag;
    logic [7:0]  rdData;
    logic [31:0] statusWord;

    // ----------------------------------------------------------
    // access decode
    // ----------------------------------------------------------
    assign accessCyc = pSel & pEnable;          // zero wait, always last cycle
    assign wrAcc     = accessCyc & pWrite;
    assign rdAcc     = accessCyc & ~pWrite;
    assign busyInt   = busy | cmdStart;         // start issued, fsm not yet busy
    assign startReq  = pWdata[`CTRL_START_BIT];

    always_comb
    begin
        case (pAddr)
            `REG_CTRL, `REG_ADDR, `REG_WDATA, `REG_RDATA, `REG_STATUS: knownOff = 1'b1;
            default: knownOff = 1'b0;
        endcase
        case (pWdata[7:0])
            OP_WREN, OP_RDSR, OP_READ, OP_PP: opLegal = 1'b1;
            default: opLegal = 1'b0;
        endcase
    end

    assign ctrlWr     = wrAcc & (pAddr == `REG_CTRL);
    assign ctrlErr    = ctrlWr & (~opLegal | (startReq & busyInt));
    assign ctrlAccept = ctrlWr & ~ctrlErr & ~busyInt;   // op frozen during a frame
    assign pSlvErr    = (accessCyc & ~knownOff) | ctrlErr;

    // control state
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            cmdStart <= 1'b0;
            cmdOp    <= OP_WREN;
            busyQ    <= 1'b0;
            doneFlag <= 1'b0;
        end
        else
        begin
            cmdStart <= ctrlAccept & startReq;  // one cycle pulse
            if (ctrlAccept)
                cmdOp <= flashOp'(pWdata[7:0]);
            busyQ    <= busy;
            doneFlag <= statusRd ? 1'b0 : (doneFlag | busyFell);    // read clears
        end
    end

    // address and write byte, ignored while a frame runs
    always_ff @(posedge iSysClk)
    begin
        if (wrAcc && pAddr == `REG_ADDR && !busyInt)
            cmdAddr <= pWdata[23:0];
        if (wrAcc && pAddr == `REG_WDATA && !busyInt)
            cmdWrByte <= pWdata[7:0];
        if (rdByteVld)
            rdData <= rdByte;                   // final miso byte
    end

    // ----------------------------------------------------------
    // status and read mux
    // ----------------------------------------------------------
    assign busyFell = busyQ & ~busy;
    assign statusRd = rdAcc & (pAddr == `REG_STATUS);

    always_comb
    begin
        statusWord = '0;
        statusWord[`STAT_BUSY_BIT] = busyInt;
        statusWord[`STAT_DONE_BIT] = doneFlag | busyFell;   // visible on the fall itself
        case (pAddr)
            `REG_CTRL:   pRdata = {23'd0, cmdStart, cmdOp};
            `REG_ADDR:   pRdata = {8'd0, cmdAddr};
            `REG_WDATA:  pRdata = {24'd0, cmdWrByte};
            `REG_RDATA:  pRdata = {24'd0, rdData};
            `REG_STATUS: pRdata = statusWord;
            default:     pRdata = '0;
        endcase
    end

    // access phase always follows a setup phase with pSel held
    apbEnableNeedsSel: assert property (@(posedge iSysClk) disable iff (!rstN)
        pEnable |-> pSel)
        else $error("pEnable high without pSel");

endmodule

/* src/flashCmdFsm.sv */
`timescale 1ns/10ps
`include "flashSpi_consts.svh"

module flashCmdFsm
(
    input  logic                 iSysClk,
    input  logic                 rstN,
    input  logic                 cmdStart,
    input  flashSpiPkg::flashOp  cmdOp,
    input  logic [23:0]          cmdAddr,
    input  logic [7:0]           cmdWrByte,
    output logic                 busy,
    output logic                 cs,
    output logic                 sckRun,
    input  logic                 byteDone,
    output logic                 loadByte,
    output logic [7:0]           txByte,
    input  logic [7:0]           rxByte,
    output logic [7:0]           rdByte,
    output logic                 rdByteVld
);

    import flashSpiPkg::*;

    localparam int              lpGapW    = $clog2(`CS_GAP_CYC + 1);
    localparam logic [lpGapW-1:0] lpGapLast = lpGapW'(`CS_GAP_CYC - 1);

    cmdState           state;
    logic [lpGapW-1:0] gapCnt;      // cs setup / hold
    logic [1:0]        addrIdx;     // address byte just sent
    logic              hasAddr, hasData, isRead;
    logic [7:0]        dataByte;

    // ----------------------------------------------------------
    // opcode properties
    // ----------------------------------------------------------
    assign hasAddr  = (cmdOp == OP_READ) || (cmdOp == OP_PP);
    assign hasData  = (cmdOp != OP_WREN);
    assign isRead   = (cmdOp == OP_READ) || (cmdOp == OP_RDSR);
    assign dataByte = (cmdOp == OP_PP) ? cmdWrByte : 8'hFF;    // dummy on reads

    // next byte for the shifter, loaded while idle or on byteDone
    always_comb
    begin
        loadByte = 1'b0;
        txByte   = dataByte;
        case (state)
            IDLE:
            begin
                loadByte = cmdStart;
                txByte   = cmdOp;               // opcode ready before cs falls
            end
            SEND_OP:
            begin
                loadByte = byteDone & hasData;  // wren ends here
                if (hasAddr)
                    txByte = cmdAddr[23:16];
            end
            SEND_ADDR:
            begin
                loadByte = byteDone;
                case (addrIdx)
                    2'd0:    txByte = cmdAddr[15:8];
                    2'd1:    txByte = cmdAddr[7:0];
                    default: txByte = dataByte;
                endcase
            end
            default: loadByte = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // frame sequencing
    // ----------------------------------------------------------
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            state     <= IDLE;
            cs        <= 1'b1;
            busy      <= 1'b0;
            sckRun    <= 1'b0;
            gapCnt    <= '0;
            addrIdx   <= '0;
            rdByteVld <= 1'b0;
        end
        else
        begin
            rdByteVld <= 1'b0;
            case (state)
                IDLE:
                    if (cmdStart)
                    begin
                        state  <= CS_SETUP;
                        cs     <= 1'b0;
                        busy   <= 1'b1;
                        gapCnt <= '0;
                    end
                CS_SETUP:
                    if (gapCnt == lpGapLast)
                    begin
                        state  <= SEND_OP;
                        sckRun <= 1'b1;         // stays high across bytes
                    end
                    else
                        gapCnt <= gapCnt + 1'b1;
                SEND_OP:
                    if (byteDone)
                    begin
                        if (hasAddr)
                        begin
                            state   <= SEND_ADDR;
                            addrIdx <= '0;
                        end
                        else if (hasData)
                            state <= XFER_DATA;
                        else
                        begin
                            state  <= CS_HOLD;
                            sckRun <= 1'b0;
                            gapCnt <= '0;
                        end
                    end
                SEND_ADDR:
                    if (byteDone)
                    begin
                        if (addrIdx == 2'd2)
                            state <= XFER_DATA;
                        else
                            addrIdx <= addrIdx + 1'b1;
                    end
                XFER_DATA:
                    if (byteDone)
                    begin
                        state     <= CS_HOLD;
                        sckRun    <= 1'b0;
                        gapCnt    <= '0;
                        rdByteVld <= isRead;
                    end
                CS_HOLD:
                    if (gapCnt == lpGapLast)
                    begin
                        state <= IDLE;
                        cs    <= 1'b1;
                        busy  <= 1'b0;          // same clock as cs rise
                    end
                    else
                        gapCnt <= gapCnt + 1'b1;
                default: state <= IDLE;
            endcase
        end
    end

    // miso byte is complete on the last byteDone
    always_ff @(posedge iSysClk)
    begin
        if (state == XFER_DATA && byteDone && isRead)
            rdByte <= rxByte;
    end

    // register bank only pulses start between frames
    startWhileIdle: assert property (@(posedge iSysClk) disable iff (!rstN)
        cmdStart |-> !busy)
        else $error("cmdStart while a frame is running");

endmodule

/* src/spiSckTimer.sv */
`timescale 1ns/10ps
`include "flashSpi_consts.svh"

module spiSckTimer
(
    input  logic iSysClk,
    input  logic rstN,
    input  logic sckRun,
    output logic sck,
    output logic byteDone,
    output logic shiftStb,
    output logic sampleStb
);

    localparam int                 lpDivW     = $clog2(`FLASH_CLK_DIV);
    localparam logic [lpDivW-1:0]  lpDivLast  = lpDivW'(`FLASH_CLK_DIV - 1);
    localparam int                 lpHoldW    = $clog2(`FLASH_HOLD_CYC + 1);
    localparam logic [lpHoldW-1:0] lpHoldLast = lpHoldW'(`FLASH_HOLD_CYC - 1);

    typedef enum logic
    {
        HOLD_IDLE,
        HOLD_RUN
    } holdState;

    logic [lpDivW-1:0]  divCnt;
    logic [2:0]         bitCnt;     // falling edges within the byte
    logic [lpHoldW-1:0] holdCnt;
    holdState           holdSt;
    logic               divHit, sckFall, sckRise, holdHit;

    // ----------------------------------------------------------
    // divider and sck, mode 0
    // ----------------------------------------------------------
    assign divHit  = sckRun & (divCnt == lpDivLast);
    assign sckFall = divHit & sck;
    assign sckRise = divHit & ~sck;

    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            divCnt   <= '0;
            sck      <= 1'b0;
            bitCnt   <= '0;
            byteDone <= 1'b0;
        end
        else if (!sckRun)
        begin
            divCnt   <= '0;             // restart phase for the next byte
            sck      <= 1'b0;           // idle low
            bitCnt   <= '0;
            byteDone <= 1'b0;
        end
        else
        begin
            divCnt   <= divHit ? '0 : divCnt + 1'b1;
            if (divHit)
                sck <= ~sck;
            if (sckFall)
                bitCnt <= bitCnt + 1'b1;            // wraps after eight
            byteDone <= sckFall & (bitCnt == 3'd7);
        end
    end

    assign sampleStb = sckRise;     // miso taken with the rising edge

    // ----------------------------------------------------------
    // mosi hold timer
    // no shift after the 8th fall, the next byte is loaded then
    // ----------------------------------------------------------
    assign holdHit  = holdCnt == lpHoldLast;
    assign shiftStb = (holdSt == HOLD_RUN) & holdHit;

    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            holdSt  <= HOLD_IDLE;
            holdCnt <= '0;
        end
        else if (!sckRun)
        begin
            holdSt  <= HOLD_IDLE;
            holdCnt <= '0;
        end
        else
        begin
            case (holdSt)
                HOLD_IDLE:
                begin
                    holdCnt <= '0;
                    if (sckFall && bitCnt != 3'd7)
                        holdSt <= HOLD_RUN;
                end
                HOLD_RUN:
                begin
                    holdCnt <= holdHit ? '0 : holdCnt + 1'b1;
                    if (holdHit)
                        holdSt <= HOLD_IDLE;
                end
                default: holdSt <= HOLD_IDLE;
            endcase
        end
    end

    sckIdleLow: assert property (@(posedge iSysClk) disable iff (!rstN)
        !sckRun |-> !sck)
        else $error("sck high while sckRun low");

endmodule

/* src/spiShifter.sv */
`timescale 1ns/10ps

module spiShifter
(
    input  logic       iSysClk,
    input  logic       rstN,
    input  logic       loadByte,
    input  logic [7:0] txByte,
    input  logic       shiftStb,
    input  logic       sampleStb,
    input  logic       miso,
    output logic       mosi,
    output logic [7:0] rxByte
);

    logic [7:0] txReg;
    logic [7:0] rxReg;

    // ----------------------------------------------------------
    // transmit, msb first
    // ----------------------------------------------------------
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
            txReg <= '0;                            // mosi low out of reset
        else if (loadByte)
            txReg <= txByte;
        else if (shiftStb)
            txReg <= {txReg[6:0], 1'b1};            // ones fill behind
    end

    assign mosi = txReg[7];

    // receive, shifted on rising sck
    always_ff @(posedge iSysClk)
    begin
        if (sampleStb)
            rxReg <= {rxReg[6:0], miso};
    end

    assign rxByte = rxReg;

endmodule

/* src/flashSpiTop.sv */
`timescale 1ns/10ps

module flashSpiTop
(
    input  logic        iSysClk,
    input  logic        rstN,
    // apb
    input  logic        pSel,
    input  logic        pEnable,
    input  logic        pWrite,
    input  logic [7:0]  pAddr,
    input  logic [31:0] pWdata,
    output logic [31:0] pRdata,
    output logic        pSlvErr,
    output logic        pReady,
    // flash pins
    output logic        cs,
    output logic        sck,
    output logic        mosi,
    input  logic        miso,
    output logic        wp,
    output logic        hold
);

    import flashSpiPkg::*;

    flashOp      cmdOp;
    logic        cmdStart, busy, rdByteVld;
    logic [23:0] cmdAddr;
    logic [7:0]  cmdWrByte, rdByte, txByte, rxByte;
    logic        sckRun, byteDone, loadByte;
    logic        shiftStb, sampleStb;

    assign pReady = 1'b1;   // zero wait states
    assign wp     = 1'b1;   // write protect off
    assign hold   = 1'b1;   // never paused

    apbFlashRegs uRegs
    (
        .iSysClk   (iSysClk),
        .rstN      (rstN),
        .pSel      (pSel),
        .pEnable   (pEnable),
        .pWrite    (pWrite),
        .pAddr     (pAddr),
        .pWdata    (pWdata),
        .pRdata    (pRdata),
        .pSlvErr   (pSlvErr),
        .busy      (busy),
        .rdByte    (rdByte),
        .rdByteVld (rdByteVld),
        .cmdStart  (cmdStart),
        .cmdOp     (cmdOp),
        .cmdAddr   (cmdAddr),
        .cmdWrByte (cmdWrByte)
    );

    flashCmdFsm uFsm
    (
        .iSysClk   (iSysClk),
        .rstN      (rstN),
        .cmdStart  (cmdStart),
        .cmdOp     (cmdOp),
        .cmdAddr   (cmdAddr),
        .cmdWrByte (cmdWrByte),
        .busy      (busy),
        .cs        (cs),
        .sckRun    (sckRun),
        .byteDone  (byteDone),
        .loadByte  (loadByte),
        .txByte    (txByte),
        .rxByte    (rxByte),
        .rdByte    (rdByte),
        .rdByteVld (rdByteVld)
    );

    spiSckTimer uTimer
    (
        .iSysClk   (iSysClk),
        .rstN      (rstN),
        .sckRun    (sckRun),
        .sck       (sck),
        .byteDone  (byteDone),
        .shiftStb  (shiftStb),
        .sampleStb (sampleStb)
    );

    spiShifter uShift
    (
        .iSysClk   (iSysClk),
        .rstN      (rstN),
        .loadByte  (loadByte),
        .txByte    (txByte),
        .shiftStb  (shiftStb),
        .sampleStb (sampleStb),
        .miso      (miso),
        .mosi      (mosi),
        .rxByte    (rxByte)
    );

endmodule

/* verif/flashSpiChecker.sv */
`timescale 1ns/10ps
`include "flashSpi_consts.svh"

module flashSpiChecker
(
    input  logic        iSysClk,
    input  logic        rstN,
    input  logic        pSel,
    input  logic        pEnable,
    input  logic        pWrite,
    input  logic [7:0]  pAddr,
    input  logic [31:0] pRdata,
    input  logic        cs,
    input  logic        sck,
    input  logic        mosi,
    output int          errCount,
    output int          frameCount
);

    int         checkCount;
    int         errAtStart;
    int         bitCnt;
    logic [7:0] shiftReg;
    logic [7:0] gotBytes[$];    // bytes of the running frame
    logic [7:0] expBytes[$];
    int         expLens[$];     // one entry per expected frame
    logic [7:0] expRd[$];       // expected RDATA per read access

    initial
    begin
        errCount   = 0;
        frameCount = 0;
        checkCount = 0;
        errAtStart = 0;
        bitCnt     = 0;
        shiftReg   = 8'h00;
    end

    // ----------------------------------------------------------
    // compare helpers, called from the testbench
    // ----------------------------------------------------------
    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp)
        begin
            errCount++;
            $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, what, got, exp);
        end
    endtask

    task automatic reportFailure(input string msg);
        errCount++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic pushFrame(input logic [7:0] frame [0:4], input int n);
        for (int i = 0; i < n; i++)
            expBytes.push_back(frame[i]);
        expLens.push_back(n);
    endtask

    task automatic pushRead(input logic [7:0] b);
        expRd.push_back(b);
    endtask

    task automatic startTest();
        errAtStart = errCount;
    endtask

    task automatic endTest(input string name);
        int errs;
        errs = errCount - errAtStart;
        $display("test %s: %s, %0d errors", name, (errs == 0) ? "pass" : "fail", errs);
    endtask

    task automatic closeReport();
        $display("checks %0d, frames %0d, errors %0d", checkCount, frameCount, errCount);
    endtask

    // ----------------------------------------------------------
    // mosi frame capture between cs edges
    // ----------------------------------------------------------
    always @(negedge cs)
    begin
        gotBytes.delete();
        bitCnt = 0;
    end

    always @(posedge sck)
    begin
        if (!cs)
        begin
            shiftReg = {shiftReg[6:0], mosi};   // msb first
            bitCnt++;
            if (bitCnt == 8)
            begin
                gotBytes.push_back(shiftReg);
                bitCnt = 0;
            end
        end
    end

    always @(posedge cs)
    begin
        int n;
        logic [7:0] e;
        if (rstN === 1'b1)
        begin
            frameCount++;
            if (expLens.size() == 0)
                reportFailure("a frame was sent while no command was expected");
            else
            begin
                n = expLens.pop_front();
                checkValue("frame length", 32'(gotBytes.size()), 32'(n));
                for (int i = 0; i < n; i++)
                begin
                    e = expBytes.pop_front();
                    if (i < gotBytes.size())
                        checkValue($sformatf("mosi byte %0d", i), 32'(gotBytes[i]), 32'(e));
                end
            end
        end
    end

    // apb reads of RDATA, taken in the access cycle
    always @(posedge iSysClk)
    begin
        if (rstN && pSel && pEnable && !pWrite && pAddr == `REG_RDATA)
        begin
            if (expRd.size() == 0)
                reportFailure("RDATA was read with no expected value queued");
            else
                checkValue("RDATA", pRdata, {24'd0, expRd.pop_front()});
        end
    end

endmodule

/* verif/flashSpiTb.sv */
`timescale 1ns/10ps
`include "flashSpi_consts.svh"

module flashSpiTb;

    import flashSpiPkg::*;

    // worst case frame: start, cs gaps, five bytes
    localparam int frameMax   = 2 + 2 * `CS_GAP_CYC + 5 * 16 * `FLASH_CLK_DIV + 4;
    localparam int numFrames  = 10;
    localparam int apbPerCmd  = 40;     // setup writes and the status reads
    localparam int cycleLimit = (3 * numFrames * frameMax) / 2 + numFrames * apbPerCmd + 50;

    logic        iSysClk, rstN;
    logic        pSel, pEnable, pWrite, pSlvErr, pReady;
    logic [7:0]  pAddr;
    logic [31:0] pWdata, pRdata;
    logic        cs, sck, mosi, miso, wp, hold;
    int          errCount, frameCount, cycles;

    // flash model state
    logic [7:0]  flashMem[256];
    logic        flashWel;
    logic [7:0]  fIn, fOut, fOp, fData;
    logic [23:0] fAddr;
    int          fBit, fIdx;

    // shadow used by the reference function
    logic [7:0]  shadowMem[256];
    logic        shadowWel;

    flashSpiTop dut
    (
        .iSysClk (iSysClk),
        .rstN    (rstN),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWdata  (pWdata),
        .pRdata  (pRdata),
        .pSlvErr (pSlvErr),
        .pReady  (pReady),
        .cs      (cs),
        .sck     (sck),
        .mosi    (mosi),
        .miso    (miso),
        .wp      (wp),
        .hold    (hold)
    );

    flashSpiChecker chk
    (
        .iSysClk    (iSysClk),
        .rstN       (rstN),
        .pSel       (pSel),
        .pEnable    (pEnable),
        .pWrite     (pWrite),
        .pAddr      (pAddr),
        .pRdata     (pRdata),
        .cs         (cs),
        .sck        (sck),
        .mosi       (mosi),
        .errCount   (errCount),
        .frameCount (frameCount)
    );

    initial iSysClk = 1'b0;
    always #50 iSysClk = ~iSysClk;     // 100 ns period

    always @(posedge iSysClk)
    begin
        cycles++;
        if (cycles > cycleLimit)
        begin
            $display("timeout: the run did not finish within %0d clock cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // behavioral flash, mode 0
    // ----------------------------------------------------------
    always @(negedge cs)
    begin
        fBit = 0;
        fIdx = 0;
        fOut = 8'h00;
    end

    always @(posedge sck)
    begin
        if (!cs)
        begin
            fIn = {fIn[6:0], mosi};
            fBit++;
            if (fBit == 8)
            begin
                fBit = 0;
                case (fIdx)
                    0: fOp = fIn;
                    1: fAddr[23:16] = fIn;
                    2: fAddr[15:8] = fIn;
                    3: fAddr[7:0] = fIn;
                    default: fData = fIn;
                endcase
                if (fIdx == 0 && fIn == OP_RDSR)
                    fOut = {6'd0, flashWel, 1'b0};      // wel in bit 1
                if (fIdx == 3 && fOp == OP_READ)
                    fOut = flashMem[fAddr[7:0]];
                fIdx++;
            end
        end
    end

    always @(negedge sck)
    begin
        if (!cs)
        begin
            miso = fOut[7];                 // ready long before the next rise
            fOut = {fOut[6:0], 1'b0};
        end
    end

    always @(posedge cs)
    begin
        if (rstN === 1'b1)
        begin
            if (fIdx == 1 && fOp == OP_WREN)
                flashWel = 1'b1;
            if (fIdx == 5 && fOp == OP_PP)
            begin
                if (flashWel)
                    flashMem[fAddr[7:0]] = fData;
                flashWel = 1'b0;            // cleared by any program
            end
        end
    end

    // ----------------------------------------------------------
    // reference model: mosi bytes and read byte of one command
    // ----------------------------------------------------------
    function automatic void expectFrame(input flashOp op, input logic [23:0] addr,
                                        input logic [7:0] wbyte,
                                        output logic [7:0] frame [0:4],
                                        output int n, output logic [7:0] rd);
        frame[0] = op;
        for (int i = 1; i < 5; i++)
            frame[i] = 8'hFF;
        n  = 1;
        rd = 8'h00;
        case (op)
            OP_WREN: shadowWel = 1'b1;
            OP_RDSR:
            begin
                n  = 2;                     // dummy byte clocks the status out
                rd = {6'd0, shadowWel, 1'b0};
            end
            default:
            begin
                frame[1] = addr[23:16];
                frame[2] = addr[15:8];
                frame[3] = addr[7:0];
                n = 5;
                if (op == OP_READ)
                    rd = shadowMem[addr[7:0]];
                else
                begin
                    frame[4] = wbyte;
                    if (shadowWel)
                        shadowMem[addr[7:0]] = wbyte;
                    shadowWel = 1'b0;
                end
            end
        endcase
    endfunction

    // apb, driven on the falling edge, zero wait states
    task automatic apbWrite(input logic [7:0] a, input logic [31:0] d, output logic err);
        @(negedge iSysClk);
        pSel    = 1'b1;
        pEnable = 1'b0;
        pWrite  = 1'b1;
        pAddr   = a;
        pWdata  = d;
        @(negedge iSysClk);
        pEnable = 1'b1;
        #1;
        err = pSlvErr;
        @(negedge iSysClk);
        pSel    = 1'b0;
        pEnable = 1'b0;
    endtask

    task automatic apbRead(input logic [7:0] a, output logic [31:0] d, output logic err);
        @(negedge iSysClk);
        pSel    = 1'b1;
        pEnable = 1'b0;
        pWrite  = 1'b0;
        pAddr   = a;
        @(negedge iSysClk);
        pEnable = 1'b1;
        #1;
        d   = pRdata;
        err = pSlvErr;
        @(negedge iSysClk);
        pSel    = 1'b0;
        pEnable = 1'b0;
    endtask

    // one command end to end, with status polling
    task automatic runCmd(input flashOp op, input logic [23:0] a, input logic [7:0] wb,
                          output logic [7:0] rd);
        logic [7:0]  fr [0:4];
        int          n;
        logic [7:0]  expRd;
        logic        err;
        logic [31:0] st;
        apbWrite(`REG_ADDR, {8'd0, a}, err);
        chk.checkValue("ADDR write error", 32'(err), 32'd0);
        apbWrite(`REG_WDATA, {24'd0, wb}, err);
        chk.checkValue("WDATA write error", 32'(err), 32'd0);
        expectFrame(op, a, wb, fr, n, expRd);
        chk.pushFrame(fr, n);
        apbWrite(`REG_CTRL, {23'd0, 1'b1, op}, err);
        chk.checkValue("CTRL start error", 32'(err), 32'd0);
        apbRead(`REG_STATUS, st, err);
        chk.checkValue("busy during frame", 32'(st[0]), 32'd1);
        while (st[0])
            apbRead(`REG_STATUS, st, err);  // cycle counter bounds this
        chk.checkValue("done after frame", 32'(st[1]), 32'd1);
        apbRead(`REG_STATUS, st, err);
        chk.checkValue("done cleared by read", 32'(st[1]), 32'd0);
        rd = 8'h00;
        if (op == OP_RDSR || op == OP_READ)
        begin
            chk.pushRead(expRd);
            apbRead(`REG_RDATA, st, err);
            rd = st[7:0];
        end
    endtask

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial
    begin
        logic [23:0] a;
        logic [7:0]  d, r;
        logic        err;
        logic [31:0] st;
        int          framesBefore;
        logic [7:0]  fr [0:4];
        int          fn;
        logic [7:0]  rs;
        void'($urandom(32'h4ea0_83f7));
        cycles  = 0;
        rstN    = 1'b0;
        pSel    = 1'b0;
        pEnable = 1'b0;
        pWrite  = 1'b0;
        pAddr   = 8'h00;
        pWdata  = 32'h0;
        miso    = 1'b0;
        fIn     = 8'h00;
        fOp     = 8'h00;
        fData   = 8'h00;
        fAddr   = 24'h0;
        flashWel  = 1'b0;
        shadowWel = 1'b0;
        for (int i = 0; i < 256; i++)
        begin
            flashMem[i]  = 8'(i * 37) ^ 8'hA5;
            shadowMem[i] = flashMem[i];
        end
        repeat (3) @(posedge iSysClk);
        @(negedge iSysClk);
        rstN = 1'b1;

        chk.startTest();
        chk.checkValue("pReady tie", 32'(pReady), 32'd1);
        chk.checkValue("wp pin", 32'(wp), 32'd1);     // write protect inactive
        chk.checkValue("hold pin", 32'(hold), 32'd1);
        chk.endTest("pin ties");

        chk.startTest();
        runCmd(OP_WREN, 24'h0, 8'h00, r);
        runCmd(OP_RDSR, 24'h0, 8'h00, r);
        chk.checkValue("status wel", 32'(r), 32'h02);
        chk.endTest("wren then rdsr");

        chk.startTest();
        a = 24'($urandom);
        d = 8'($urandom);
        runCmd(OP_WREN, 24'h0, 8'h00, r);
        runCmd(OP_PP, a, d, r);
        runCmd(OP_READ, a, 8'h00, r);
        chk.checkValue("read back", 32'(r), 32'(d));
        chk.endTest("program and read");

        chk.startTest();
        runCmd(OP_PP, a, ~d, r);            // wel already cleared
        runCmd(OP_READ, a, 8'h00, r);
        chk.checkValue("unchanged byte", 32'(r), 32'(d));
        chk.endTest("program without wren");

        chk.startTest();
        runCmd(OP_READ, 24'($urandom), 8'h00, r);
        framesBefore = frameCount;
        expectFrame(OP_RDSR, 24'h0, 8'h00, fr, fn, rs);
        chk.pushFrame(fr, fn);
        apbWrite(`REG_CTRL, {23'd0, 1'b1, OP_RDSR}, err);
        chk.checkValue("legal start error", 32'(err), 32'd0);
        // that start is legal; refuse a second one while it runs
        apbWrite(`REG_CTRL, {23'd0, 1'b1, OP_WREN}, err);
        chk.checkValue("start while busy error", 32'(err), 32'd1);
        apbRead(`REG_STATUS, st, err);
        while (st[0])
            apbRead(`REG_STATUS, st, err);
        chk.checkValue("frames after busy start", 32'(frameCount), 32'(framesBefore + 1));
        framesBefore = frameCount;
        apbWrite(`REG_CTRL, {23'd0, 1'b1, 8'h9F}, err);
        chk.checkValue("unknown opcode error", 32'(err), 32'd1);
        repeat (2 * `CS_GAP_CYC) @(negedge iSysClk);
        chk.checkValue("cs idle after refused start", 32'(cs), 32'd1);
        chk.checkValue("frame count", 32'(frameCount), 32'(framesBefore));
        chk.endTest("refused starts");

        chk.startTest();
        runCmd(OP_WREN, 24'h0, 8'h00, r);
        chk.endTest("status polling");

        chk.closeReport();
        if (errCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* flashSpi.f */
+incdir+src
src/flashSpiPkg.sv
src/apbFlashRegs.sv
src/flashCmdFsm.sv
src/spiSckTimer.sv
src/spiShifter.sv
src/flashSpiTop.sv
verif/flashSpiChecker.sv
verif/flashSpiTb.sv

/* Makefile */
# Verilator lint, simulation and clean for flashSpi

TOP := flashSpiTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flashSpi.f

obj_dir/V$(TOP): flashSpi.f src/*.sv src/*.svh verif/*.sv
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f flashSpi.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then exit 1; fi
	@if grep -q "CHECKS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
